/* ppu_params.svh */
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// Line and frame timing counted in dots
`define PPU_DOTS_PER_LINE    456
`define PPU_LINES_PER_FRAME  154
`define PPU_VISIBLE_LINES    144   // Line 144 is the first VBlank line
`define PPU_OAM_DOTS         80    // Mode 3 begins at this dot
`define PPU_DRAW_END_DOT     252   // Mode 0 begins at this dot
`define PPU_TILES_PER_LINE   20

// CPU addresses of the registers
`define PPU_ADDR_LCDC        16'hFF40
`define PPU_ADDR_STAT        16'hFF41
`define PPU_ADDR_LY          16'hFF44
`define PPU_ADDR_LYC         16'hFF45
`define PPU_ADDR_BGP         16'hFF47

// Where VRAM sits in the CPU map
`define PPU_VRAM_BASE        16'h8000
`define PPU_VRAM_SIZE        16'h2000

// Offsets inside VRAM for the two tile maps
`define PPU_MAP0_BASE        13'h1800
`define PPU_MAP1_BASE        13'h1C00

// Tile data origin used when LCDC bit 4 is clear
`define PPU_SIGNED_DATA_BASE 13'h1000

`endif

/* ppuPkg.sv */
package ppuPkg;

   typedef enum logic [1:0] {
      hBlank  = 2'd0,
      vBlank  = 2'd1,
      oamScan = 2'd2,
      drawing = 2'd3
   } ppuMode_t;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  writeData;
      logic        write;
      logic        read;
   } cpuBus_t;

   typedef struct packed {
      logic [12:0] addr;         // Offset inside VRAM
      logic [7:0]  writeData;
      logic        write;
   } vramReq_t;

   typedef struct packed {
      logic [7:0] ly;
      logic [8:0] dot;
      ppuMode_t   mode;
      logic       coincidence;
   } lineState_t;

   // Tile map entry byte seen as 0..255 or as -128..127 depending on LCDC bit 4
   typedef union packed {
      logic [7:0]        unsignedIndex;
      logic signed [7:0] signedIndex;
   } tileIndex_u;

   typedef struct packed {
      logic [4:0] tileX;
      logic [7:0] ly;
      logic [7:0] lowPlane;
      logic [7:0] highPlane;
   } tileRow_t;

   typedef struct packed {
      logic [4:0]      tileX;
      logic [7:0]      ly;
      logic [0:7][1:0] shades;   // Element 0 is the leftmost pixel
   } shadeRow_t;

endpackage

/* lineTiming.sv */
`timescale 1ns/1ps
`include "ppu_params.svh"

module lineTiming (
   input  logic               clock,
   input  logic               reset,
   input  logic               enable,
   input  logic [7:0]         lyc,
   output ppuPkg::lineState_t state
);
   import ppuPkg::*;

   logic [8:0] dot;
   logic [7:0] ly;

   always_ff @(posedge clock) begin
      if (reset) begin
         dot <= '0;
         ly  <= '0;
      end else if (!enable) begin
         dot <= '0;   // Display off parks the beam at the top left
         ly  <= '0;
      end else if (dot == 9'(`PPU_DOTS_PER_LINE - 1)) begin
         dot <= '0;
         ly  <= (ly == 8'(`PPU_LINES_PER_FRAME - 1)) ? 8'd0 : ly + 8'd1;
      end else begin
         dot <= dot + 9'd1;
      end
   end

   always_comb begin
      state.ly          = ly;
      state.dot         = dot;
      state.coincidence = (ly == lyc);
      if (ly >= 8'(`PPU_VISIBLE_LINES)) begin
         state.mode = vBlank;
      end else if (dot < 9'(`PPU_OAM_DOTS)) begin
         state.mode = oamScan;
      end else if (dot < 9'(`PPU_DRAW_END_DOT)) begin
         state.mode = drawing;
      end else begin
         state.mode = hBlank;
      end
   end

   dotInRange: assert property (
      @(posedge clock) disable iff (reset)
      dot <= 9'(`PPU_DOTS_PER_LINE - 1)
   ) else $error("Dot counter ran past the end of the line");

   lineInRange: assert property (
      @(posedge clock) disable iff (reset)
      ly <= 8'(`PPU_LINES_PER_FRAME - 1)
   ) else $error("LY ran past the end of the frame");

endmodule

/* ppuCpuPort.sv */
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppuCpuPort (
   input  logic               clock,
   input  logic               reset,
   input  ppuPkg::cpuBus_t    cpu,
   output logic [7:0]         cpuReadData,
   input  ppuPkg::lineState_t state,
   input  logic [12:0]        fetchAddr,
   output ppuPkg::vramReq_t   vram,
   input  logic [7:0]         vramReadData,
   output logic [7:0]         lcdc,
   output logic [7:0]         lyc,
   output logic [7:0]         bgp,
   output logic               vblankIrq,
   output logic               statIrq
);
   import ppuPkg::*;

   logic [3:0]  statEnable;   // STAT bits 6 down to 3
   logic        cpuVram;
   logic        drawingNow;
   logic [15:0] vramOffset;
   logic [7:0]  regReadValue;
   logic [7:0]  readHold;
   logic        vramPending;  // Memory answers the previous CPU read in this cycle

   assign drawingNow = (state.mode == drawing);
   assign cpuVram    = (cpu.addr >= `PPU_VRAM_BASE) &&
                       (cpu.addr < `PPU_VRAM_BASE + `PPU_VRAM_SIZE);
   assign vramOffset = cpu.addr - `PPU_VRAM_BASE;

   always_ff @(posedge clock) begin
      if (reset) begin
         lcdc       <= '0;
         statEnable <= '0;
         lyc        <= '0;
         bgp        <= '0;
      end else if (cpu.write) begin
         case (cpu.addr)
            `PPU_ADDR_LCDC: lcdc       <= cpu.writeData;
            `PPU_ADDR_STAT: statEnable <= cpu.writeData[6:3];
            `PPU_ADDR_LYC:  lyc        <= cpu.writeData;
            `PPU_ADDR_BGP:  bgp        <= cpu.writeData;
            default: ;                   // LY is read only
         endcase
      end
   end

   // VRAM addresses land on 0xFF here, which is the answer when mode 3 blocks them
   always_comb begin
      case (cpu.addr)
         `PPU_ADDR_LCDC: regReadValue = lcdc;
         `PPU_ADDR_STAT: regReadValue = {1'b0, statEnable, state.coincidence, state.mode};
         `PPU_ADDR_LY:   regReadValue = state.ly;
         `PPU_ADDR_LYC:  regReadValue = lyc;
         `PPU_ADDR_BGP:  regReadValue = bgp;
         default:        regReadValue = 8'hFF;
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         readHold    <= '0;
         vramPending <= 1'b0;
      end else if (cpu.read) begin
         readHold    <= regReadValue;
         vramPending <= cpuVram && !drawingNow;
      end else if (vramPending) begin
         readHold    <= vramReadData;   // Keep the memory byte until the next read
         vramPending <= 1'b0;
      end
   end

   assign cpuReadData = vramPending ? vramReadData : readHold;

   // Renderer owns the memory for the whole of mode 3
   always_comb begin
      vram.writeData = cpu.writeData;
      if (drawingNow) begin
         vram.addr  = fetchAddr;
         vram.write = 1'b0;
      end else begin
         vram.addr  = vramOffset[12:0];
         vram.write = cpu.write && cpuVram;
      end
   end

   assign vblankIrq = (state.mode == vBlank);
   assign statIrq   = (statEnable[3] && state.coincidence) ||
                      (statEnable[2] && state.mode == oamScan) ||
                      (statEnable[1] && state.mode == vBlank) ||
                      (statEnable[0] && state.mode == hBlank);

   noWriteWhileDrawing: assert property (
      @(posedge clock) disable iff (reset)
      state.mode == drawing |-> !vram.write
   ) else $error("VRAM written while the renderer owns it");

endmodule

/* tileFetcher.sv */
`timescale 1ns/1ps
`include "ppu_params.svh"

module tileFetcher (
   input  logic               clock,
   input  logic               reset,
   input  ppuPkg::lineState_t state,
   input  logic [7:0]         lcdc,
   output logic [12:0]        fetchAddr,
   input  logic [7:0]         vramReadData,
   output ppuPkg::tileRow_t   row,
   output logic               rowValid
);
   import ppuPkg::*;

   logic               active;
   logic               fetching;
   logic [2:0]         step;
   logic [4:0]         tileX;
   logic [7:0]         mapByte;
   logic [7:0]         lowPlane;
   tileIndex_u         tileIndex;
   logic signed [12:0] signedOffset;
   logic [12:0]        tileBase;
   logic [12:0]        mapAddr;
   logic [12:0]        planeAddr;

   // A line's fetch starts on the first drawing dot and stops after the last tile
   assign fetching = (state.mode == drawing) &&
                     (active || state.dot == 9'(`PPU_OAM_DOTS));

   // Map row is LY/8 with 32 entries per row
   assign mapAddr = (lcdc[3] ? `PPU_MAP1_BASE : `PPU_MAP0_BASE) +
                    {3'b000, state.ly[7:3], tileX};

   // In step 2 the map byte is still on the read bus, after that it sits in mapByte
   assign tileIndex    = (step == 3'd2) ? vramReadData : mapByte;
   assign signedOffset = tileIndex.signedIndex * 13'sd16;

   always_comb begin
      if (lcdc[4]) begin
         tileBase = {1'b0, tileIndex.unsignedIndex, 4'b0000};
      end else begin
         tileBase = `PPU_SIGNED_DATA_BASE + signedOffset;
      end
   end

   // Steps 2 and 3 address the low plane, steps 4 and 5 the high plane
   assign planeAddr = tileBase + {9'd0, state.ly[2:0], step[2]};
   assign fetchAddr = (step < 3'd2) ? mapAddr : planeAddr;

   always_ff @(posedge clock) begin
      if (reset) begin
         active   <= 1'b0;
         step     <= '0;
         tileX    <= '0;
         rowValid <= 1'b0;
      end else begin
         rowValid <= 1'b0;
         if (!fetching) begin
            active <= 1'b0;   // Idle keeps the tile counter at zero for the next line
            step   <= '0;
            tileX  <= '0;
         end else if (step == 3'd5) begin
            step     <= '0;
            rowValid <= 1'b1;
            if (tileX == 5'(`PPU_TILES_PER_LINE - 1)) begin
               active <= 1'b0;
               tileX  <= '0;
            end else begin
               active <= 1'b1;
               tileX  <= tileX + 5'd1;
            end
         end else begin
            active <= 1'b1;
            step   <= step + 3'd1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (fetching) begin
         case (step)
            3'd2: mapByte  <= vramReadData;
            3'd4: lowPlane <= vramReadData;
            3'd5: begin
               row.tileX     <= tileX;
               row.ly        <= state.ly;
               row.lowPlane  <= lowPlane;
               row.highPlane <= vramReadData;
            end
            default: ;
         endcase
      end
   end

   rowOnlyWhileDrawing: assert property (
      @(posedge clock) disable iff (reset)
      rowValid |-> state.mode == drawing
   ) else $error("Tile row delivered outside mode 3");

endmodule

/* pixelShader.sv */
`timescale 1ns/1ps

module pixelShader (
   input  logic              clock,
   input  logic              reset,
   input  ppuPkg::tileRow_t  row,
   input  logic              rowValid,
   input  logic [7:0]        bgp,
   output ppuPkg::shadeRow_t shade,
   output logic              shadeValid
);

   logic [0:7][1:0] colour;
   logic [0:7][1:0] shades;

   // Bit 7 of each plane is the leftmost pixel
   always_comb begin
      for (int k = 0; k < 8; k++) begin
         colour[k] = {row.highPlane[7 - k], row.lowPlane[7 - k]};
         shades[k] = bgp[2 * colour[k] +: 2];
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         shadeValid <= 1'b0;
      end else begin
         shadeValid <= rowValid;
      end
   end

   always_ff @(posedge clock) begin
      if (rowValid) begin
         shade.tileX  <= row.tileX;
         shade.ly     <= row.ly;
         shade.shades <= shades;   // BGP is sampled as the row arrives
      end
   end

endmodule

/* ppuTop.sv */
`timescale 1ns/1ps

module ppuTop (
   input  logic              clock,
   input  logic              reset,
   input  ppuPkg::cpuBus_t   cpu,
   output logic [7:0]        cpuReadData,
   output ppuPkg::vramReq_t  vram,
   input  logic [7:0]        vramReadData,
   output ppuPkg::shadeRow_t shade,
   output logic              shadeValid,
   output logic              vblankIrq,
   output logic              statIrq
);
   import ppuPkg::*;

   lineState_t  lineState;
   logic [7:0]  lcdc;
   logic [7:0]  lyc;
   logic [7:0]  bgp;
   logic [12:0] fetchAddr;
   tileRow_t    row;
   logic        rowValid;

   lineTiming timing_i (
      .clock  (clock),
      .reset  (reset),
      .enable (lcdc[7]),   // LCDC bit 7 switches the display on
      .lyc    (lyc),
      .state  (lineState)
   );

   ppuCpuPort cpuPort_i (
      .clock        (clock),
      .reset        (reset),
      .cpu          (cpu),
      .cpuReadData  (cpuReadData),
      .state        (lineState),
      .fetchAddr    (fetchAddr),
      .vram         (vram),
      .vramReadData (vramReadData),
      .lcdc         (lcdc),
      .lyc          (lyc),
      .bgp          (bgp),
      .vblankIrq    (vblankIrq),
      .statIrq      (statIrq)
   );

   tileFetcher fetcher_i (
      .clock        (clock),
      .reset        (reset),
      .state        (lineState),
      .lcdc         (lcdc),
      .fetchAddr    (fetchAddr),
      .vramReadData (vramReadData),
      .row          (row),
      .rowValid     (rowValid)
   );

   pixelShader shader_i (
      .clock      (clock),
      .reset      (reset),
      .row        (row),
      .rowValid   (rowValid),
      .bgp        (bgp),
      .shade      (shade),
      .shadeValid (shadeValid)
   );

endmodule

/* ppuTb.sv */
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppuTb;
   import ppuPkg::*;

   localparam int clockPeriod   = 10;
   localparam int visibleCycles = `PPU_VISIBLE_LINES * `PPU_DOTS_PER_LINE;
   localparam int frameCycles   = `PPU_DOTS_PER_LINE * `PPU_LINES_PER_FRAME;
   // Four of the tests run for close to one frame each
   localparam int watchdogCycles = 5 * frameCycles + 5000;

   logic       clock;
   logic       reset;
   cpuBus_t    cpu;
   logic [7:0] cpuReadData;
   vramReq_t   vram;
   logic [7:0] vramReadData;
   shadeRow_t  shade;
   logic       shadeValid;
   logic       vblankIrq;
   logic       statIrq;

   logic [7:0] vramModel [0:`PPU_VRAM_SIZE - 1];
   shadeRow_t  captured[$];
   int         dotTime;   // Cycles since the display was last switched on
   int         errorCount;
   int         testErrors;
   int         testCount;
   int         failedTests;

   ppuTop dut_i (
      .clock        (clock),
      .reset        (reset),
      .cpu          (cpu),
      .cpuReadData  (cpuReadData),
      .vram         (vram),
      .vramReadData (vramReadData),
      .shade        (shade),
      .shadeValid   (shadeValid),
      .vblankIrq    (vblankIrq),
      .statIrq      (statIrq)
   );

   initial begin
      clock = 1'b0;
      forever #(clockPeriod / 2) clock = ~clock;
   end

   // External VRAM with a one cycle read
   always @(posedge clock) begin
      if (vram.write) begin
         vramModel[vram.addr] <= vram.writeData;
      end
      vramReadData <= vramModel[vram.addr];
   end

   always @(negedge clock) begin
      if (shadeValid) begin
         captured.push_back(shade);   // No back-pressure, so every pulse is kept
      end
   end

   initial begin
      #(watchdogCycles * clockPeriod);
      $display("ERROR watchdog: the run did not finish within %0d cycles", watchdogCycles);
      $display("Test failed");
      $finish;
   end

   function automatic logic [31:0] xorshift(logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic ppuMode_t expectedMode(int t);
      int dot;
      int line;
      dot  = t % `PPU_DOTS_PER_LINE;
      line = (t / `PPU_DOTS_PER_LINE) % `PPU_LINES_PER_FRAME;
      if (line >= `PPU_VISIBLE_LINES) return vBlank;
      if (dot < `PPU_OAM_DOTS) return oamScan;
      if (dot < `PPU_DRAW_END_DOT) return drawing;
      return hBlank;
   endfunction

   function automatic logic [7:0] expectedLy(int t);
      return 8'((t / `PPU_DOTS_PER_LINE) % `PPU_LINES_PER_FRAME);
   endfunction

   function automatic shadeRow_t expectedRow(int line, int x, logic [7:0] lcdcValue,
                                             logic [7:0] bgpValue);
      int         mapAddr;
      int         dataAddr;
      int         n;
      logic [7:0] entry;
      logic [7:0] low;
      logic [7:0] high;
      shadeRow_t  r;
      mapAddr = (lcdcValue[3] ? `PPU_MAP1_BASE : `PPU_MAP0_BASE) + (line / 8) * 32 + x;
      entry   = vramModel[mapAddr];
      if (lcdcValue[4]) begin
         dataAddr = int'(entry) * 16;
      end else begin
         dataAddr = `PPU_SIGNED_DATA_BASE + int'($signed(entry)) * 16;
      end
      dataAddr = dataAddr + (line % 8) * 2;
      low      = vramModel[dataAddr];
      high     = vramModel[dataAddr + 1];
      r.tileX  = 5'(x);
      r.ly     = 8'(line);
      for (int k = 0; k < 8; k++) begin
         n = 2 * high[7 - k] + low[7 - k];
         r.shades[k] = 2'((bgpValue >> (2 * n)) & 8'h03);
      end
      return r;
   endfunction

   task automatic noteError();
      errorCount++;
      testErrors++;
   endtask

   task automatic checkByte(string name, logic [7:0] expected, logic [7:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         noteError();
      end
   endtask

   task automatic checkBit(string name, logic expected, logic actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
         noteError();
      end
   endtask

   task automatic checkMode(string name, ppuMode_t expected, ppuMode_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %s, actual %s", name, expected.name(),
                  actual.name());
         noteError();
      end
   endtask

   task automatic checkShadeRow(string name, shadeRow_t expected, shadeRow_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         noteError();
      end
   endtask

   task automatic checkCount(string name, int expected, int actual);
      if (actual != expected) begin
         $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
         noteError();
      end
   endtask

   task automatic finishTest(string name);
      testCount++;
      if (testErrors == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, testErrors);
         failedTests++;
      end
      testErrors = 0;
   endtask

   task automatic cpuWrite(logic [15:0] addr, logic [7:0] data);
      cpu.addr      = addr;
      cpu.writeData = data;
      cpu.write     = 1'b1;
      cpu.read      = 1'b0;
      @(posedge clock);
      #1;
      cpu.write = 1'b0;
      dotTime++;
   endtask

   task automatic cpuRead(logic [15:0] addr, output logic [7:0] data);
      cpu.addr  = addr;
      cpu.write = 1'b0;
      cpu.read  = 1'b1;
      @(posedge clock);
      #1;
      cpu.read = 1'b0;
      data     = cpuReadData;
      dotTime++;
   endtask

   task automatic waitCycles(int n);
      repeat (n) @(posedge clock);
      #1;
      dotTime = dotTime + n;
   endtask

   task automatic waitUntil(int t);
      if (t > dotTime) begin
         waitCycles(t - dotTime);
      end
   endtask

   // Display off parks the counters, so dot 0 of line 0 follows the enable write
   task automatic enableDisplay(logic [7:0] lcdcValue);
      cpuWrite(`PPU_ADDR_LCDC, 8'h00);
      waitCycles(2);
      captured.delete();
      cpuWrite(`PPU_ADDR_LCDC, lcdcValue);
      dotTime = 0;
   endtask

   task automatic waitVblank(string name, logic level, int limit);
      int n;
      n = 0;
      while (vblankIrq !== level && n < limit) begin
         waitCycles(1);
         n++;
      end
      if (vblankIrq !== level) begin
         $display("ERROR %s: vblankIrq never went to %b within %0d cycles", name, level, limit);
         noteError();
      end
   endtask

   task automatic checkLine(string name, int line, logic [7:0] lcdcValue, logic [7:0] bgpValue);
      int found;
      found = 0;
      foreach (captured[i]) begin
         if (captured[i].ly == line) begin
            checkShadeRow(name, expectedRow(line, found, lcdcValue, bgpValue), captured[i]);
            found++;
         end
      end
      checkCount({name, " records on the line"}, `PPU_TILES_PER_LINE, found);
   endtask

   task automatic registerAccess();
      logic [7:0] data;
      cpuWrite(`PPU_ADDR_LCDC, 8'h3B);
      cpuWrite(`PPU_ADDR_LYC, 8'h05);
      cpuWrite(`PPU_ADDR_STAT, 8'h7F);
      cpuWrite(`PPU_ADDR_BGP, 8'hE4);
      cpuWrite(`PPU_ADDR_LY, 8'h33);
      cpuRead(`PPU_ADDR_LCDC, data);
      checkByte("registerAccess LCDC", 8'h3B, data);
      cpuRead(`PPU_ADDR_STAT, data);
      checkByte("registerAccess STAT", 8'h7A, data);   // Display off sits in mode 2
      cpuRead(`PPU_ADDR_LYC, data);
      checkByte("registerAccess LYC", 8'h05, data);
      cpuRead(`PPU_ADDR_BGP, data);
      checkByte("registerAccess BGP", 8'hE4, data);
      cpuRead(`PPU_ADDR_LY, data);
      checkByte("registerAccess LY", 8'h00, data);
      cpuRead(16'hFF42, data);
      checkByte("registerAccess unmapped FF42", 8'hFF, data);
      cpuRead(16'hA000, data);
      checkByte("registerAccess unmapped A000", 8'hFF, data);
      cpuWrite(`PPU_ADDR_STAT, 8'h00);
      finishTest("registerAccess");
   endtask

   task automatic displayTiming();
      int checkpoints[13] = '{0, 78, 80, 250, 252, 454, 456, 1000, visibleCycles - 2,
                              visibleCycles, frameCycles - 2, frameCycles, frameCycles + 80};
      logic [7:0] data;
      enableDisplay(8'h80);
      foreach (checkpoints[i]) begin
         waitUntil(checkpoints[i]);
         cpuRead(`PPU_ADDR_STAT, data);
         checkMode($sformatf("displayTiming mode at %0d", checkpoints[i]),
                   expectedMode(checkpoints[i]), ppuMode_t'(data[1:0]));
         cpuRead(`PPU_ADDR_LY, data);
         checkByte($sformatf("displayTiming LY at %0d", checkpoints[i] + 1),
                   expectedLy(checkpoints[i] + 1), data);
      end
      finishTest("displayTiming");
   endtask

   task automatic renderUnsigned();
      cpuWrite(`PPU_ADDR_BGP, 8'h1B);
      enableDisplay(8'h98);
      waitVblank("renderUnsigned", 1'b1, visibleCycles + `PPU_DOTS_PER_LINE);
      checkLine("renderUnsigned", 37, 8'h98, 8'h1B);
      checkCount("renderUnsigned records in frame",
                 `PPU_VISIBLE_LINES * `PPU_TILES_PER_LINE, captured.size());
      finishTest("renderUnsigned");
   endtask

   task automatic renderSigned();
      cpuWrite(`PPU_ADDR_BGP, 8'hD2);
      enableDisplay(8'h80);
      waitVblank("renderSigned", 1'b1, visibleCycles + `PPU_DOTS_PER_LINE);
      checkLine("renderSigned", 100, 8'h80, 8'hD2);
      captured.delete();
      waitVblank("renderSigned", 1'b0, frameCycles - visibleCycles + `PPU_DOTS_PER_LINE);
      checkCount("renderSigned records during VBlank", 0, captured.size());
      finishTest("renderSigned");
   endtask

   task automatic vramSharing();
      logic [12:0] offset;
      logic [7:0]  original;
      logic [7:0]  data;
      offset   = 13'h0123;
      original = vramModel[offset];
      enableDisplay(8'h90);
      waitUntil(100);
      cpuRead(`PPU_VRAM_BASE + offset, data);
      checkByte("vramSharing read in mode 3", 8'hFF, data);
      cpuWrite(`PPU_VRAM_BASE + offset, ~original);
      checkByte("vramSharing write in mode 3", original, vramModel[offset]);
      waitUntil(300);
      cpuRead(`PPU_VRAM_BASE + offset, data);
      checkByte("vramSharing read in mode 0", original, data);
      cpuWrite(`PPU_VRAM_BASE + offset, ~original);
      checkByte("vramSharing write in mode 0", ~original, vramModel[offset]);
      cpuRead(`PPU_VRAM_BASE + offset, data);
      checkByte("vramSharing read back", ~original, data);
      finishTest("vramSharing");
   endtask

   task automatic interruptLevels();
      int times[4] = '{visibleCycles - 1, visibleCycles, frameCycles - 1, frameCycles};
      cpuWrite(`PPU_ADDR_LCDC, 8'h00);
      waitCycles(2);
      cpuWrite(`PPU_ADDR_LYC, 8'h00);
      cpuWrite(`PPU_ADDR_STAT, 8'h40);
      checkBit("interruptLevels coincidence enabled", 1'b1, statIrq);
      cpuWrite(`PPU_ADDR_LYC, 8'h05);
      checkBit("interruptLevels coincidence lost", 1'b0, statIrq);
      cpuWrite(`PPU_ADDR_STAT, 8'h08);
      enableDisplay(8'h80);
      waitUntil(100);
      checkBit("interruptLevels statIrq in mode 3", 1'b0, statIrq);
      waitUntil(300);
      checkBit("interruptLevels statIrq in hBlank", 1'b1, statIrq);
      checkBit("interruptLevels vblankIrq in hBlank", 1'b0, vblankIrq);
      cpuWrite(`PPU_ADDR_LYC, 8'h00);
      cpuWrite(`PPU_ADDR_STAT, 8'h00);   // Coincidence holds with every enable clear
      checkBit("interruptLevels all enables clear", 1'b0, statIrq);
      foreach (times[i]) begin
         waitUntil(times[i]);
         checkBit($sformatf("interruptLevels vblankIrq at %0d", times[i]),
                  expectedMode(times[i]) == vBlank, vblankIrq);
      end
      finishTest("interruptLevels");
   endtask

   initial begin
      logic [31:0] seed;
      reset        = 1'b1;
      cpu          = '0;
      vramReadData = 8'h00;
      dotTime      = 0;
      errorCount   = 0;
      testErrors   = 0;
      testCount    = 0;
      failedTests  = 0;
      seed         = 32'h36db;
      for (int a = 0; a < `PPU_VRAM_SIZE; a++) begin
         seed         = xorshift(seed);
         vramModel[a] = seed[7:0] ^ 8'(a >> 5);
      end
      // Map 0 entries all land below the signed data base
      for (int a = `PPU_MAP0_BASE; a < `PPU_MAP1_BASE; a++) begin
         vramModel[a] = vramModel[a] | 8'h80;
      end
      repeat (16) @(posedge clock);
      #1;
      reset = 1'b0;
      registerAccess();
      displayTiming();
      renderUnsigned();
      renderSigned();
      vramSharing();
      interruptLevels();
      $display("Summary: %0d tests run, %0d with errors, %0d checks failed",
               testCount, failedTests, errorCount);
      if (errorCount == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* tb.f */
+incdir+.
ppuPkg.sv
lineTiming.sv
ppuCpuPort.sv
tileFetcher.sv
pixelShader.sv
ppuTop.sv
ppuTb.sv
